/* dv/fetch_tb.sv */
// -------------------------------------------------------------------------
// Testbench for the fetch front end. Loads both memories over the host
// port, issues fetches and checks every result against a shadow model.
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module fetch_tb;

    typedef struct packed {
        logic [7:0]  pc;
        logic [1:0]  thread;
        logic [31:0] instr;
        logic [3:0]  opcode;
        logic [9:0]  d;
        logic [4:0]  d_lower;
        logic [4:0]  d_upper;
        logic [8:0]  a;
        logic [8:0]  b;
        logic [7:0]  ctrl;
    } expect_t;

    logic                clock = 1'b0;
    logic                rst_n = 1'b0;
    logic                host_wren = 1'b0;
    logic [9:0]          host_addr = '0;
    logic [31:0]         host_data = '0;
    logic                fetch_en = 1'b0;
    logic [7:0]          pc = '0;
    logic [1:0]          thread = '0;
    logic [31:0]         instr;
    fetch_pkg::opcode_e  opcode;
    logic [9:0]          d_operand;
    logic [4:0]          d_lower;
    logic [4:0]          d_upper;
    logic [8:0]          a_operand;
    logic [8:0]          b_operand;
    logic                instr_valid;
    logic [7:0]          ctrl;
    logic                ctrl_valid;

    // Shadow model of both memories and the unlock register
    logic [31:0] imem_model [256];
    logic [7:0]  ctrl_model [64];
    logic [3:0]  unlock_model = '0;

    expect_t     instr_q [$];
    expect_t     ctrl_q [$];
    logic [15:0] lfsr_q = 16'd30817;
    int          check_count = 0;
    int          check_errors = 0;
    int          flow_checks = 0;
    int          flow_errors = 0;
    int          test_num = 0;
    int          test_start_errors = 0;
    logic        burst_mode = 1'b0;

    fetch_top fetch_top_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .host_wren   (host_wren),
        .host_addr   (host_addr),
        .host_data   (host_data),
        .fetch_en    (fetch_en),
        .pc          (pc),
        .thread      (thread),
        .instr       (instr),
        .opcode      (opcode),
        .d_operand   (d_operand),
        .d_lower     (d_lower),
        .d_upper     (d_upper),
        .a_operand   (a_operand),
        .b_operand   (b_operand),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .ctrl_valid  (ctrl_valid)
    );

    always #2 clock = ~clock;

    // 16-bit Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int count);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            bits   = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // Reference model: opcode[31:28], D[27:18], A[17:9], B[8:0]
    function automatic expect_t expected_fetch(input logic [7:0] fpc, input logic [1:0] fthr);
        expect_t e;
        e.pc      = fpc;
        e.thread  = fthr;
        e.instr   = imem_model[fpc];
        e.opcode  = e.instr[31:28];
        e.d       = e.instr[27:18];
        e.d_lower = e.d[4:0];
        e.d_upper = e.d[9:5];
        e.a       = e.instr[17:9];
        e.b       = e.instr[8:0];
        e.ctrl    = ctrl_model[{fthr, e.opcode}];
        return e;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual, input expect_t e);
        check_count++;
        if (actual !== expected) begin
            check_errors++;
            $display("Mismatch %s: expected 0x%h, got 0x%h (pc 0x%h, thread %0d)",
                     name, expected, actual, e.pc, e.thread);
        end
    endtask

    // -------------------------------------------------------------------------
    // Result checker, samples on the falling edge where outputs are settled

    int      cycle_count = 0;
    int      last_instr = 0;
    int      last_ctrl = 0;
    logic    instr_seen = 1'b0;
    logic    ctrl_seen = 1'b0;
    expect_t got;

    always @(negedge clock) begin
        cycle_count++;
        if (!burst_mode) begin
            instr_seen = 1'b0;
            ctrl_seen  = 1'b0;
        end
        if (rst_n && instr_valid) begin
            if (instr_q.size() == 0) begin
                check_errors++;
                $display("instr_valid went high with no fetch outstanding");
            end else begin
                got = instr_q.pop_front();
                compare_field("instr", got.instr, instr, got);
                compare_field("opcode", 32'(got.opcode), 32'(opcode), got);
                compare_field("d_operand", 32'(got.d), 32'(d_operand), got);
                compare_field("d_lower", 32'(got.d_lower), 32'(d_lower), got);
                compare_field("d_upper", 32'(got.d_upper), 32'(d_upper), got);
                compare_field("a_operand", 32'(got.a), 32'(a_operand), got);
                compare_field("b_operand", 32'(got.b), 32'(b_operand), got);
                if (burst_mode && instr_seen && cycle_count != last_instr + 1) begin
                    check_errors++;
                    $display("Gap in burst before instruction for pc 0x%h", got.pc);
                end
                instr_seen = 1'b1;
                last_instr = cycle_count;
            end
        end
        if (rst_n && ctrl_valid) begin
            if (ctrl_q.size() == 0) begin
                check_errors++;
                $display("ctrl_valid went high with no fetch outstanding");
            end else begin
                got = ctrl_q.pop_front();
                compare_field("ctrl", 32'(got.ctrl), 32'(ctrl), got);
                if (burst_mode && ctrl_seen && cycle_count != last_ctrl + 1) begin
                    check_errors++;
                    $display("Gap in burst before control word for pc 0x%h", got.pc);
                end
                ctrl_seen = 1'b1;
                last_ctrl = cycle_count;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Stimulus tasks, all entered 1 ns after a rising edge

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic host_write(input logic [9:0] addr, input logic [31:0] data);
        host_wren = 1'b1;
        host_addr = addr;
        host_data = data;
        case (fetch_pkg::host_region_e'(addr[9:8]))
            fetch_pkg::region_imem:   imem_model[addr[7:0]] = data;
            fetch_pkg::region_cmem: begin
                if (unlock_model[addr[5:4]]) begin
                    ctrl_model[addr[5:0]] = data[7:0];
                end
            end
            fetch_pkg::region_unlock: unlock_model = data[3:0];
            default: ;
        endcase
        step();
        host_wren = 1'b0;
    endtask

    task automatic fetch_one(input logic [7:0] fetch_pc, input logic [1:0] fetch_thread);
        expect_t e;
        e = expected_fetch(fetch_pc, fetch_thread);
        instr_q.push_back(e);
        ctrl_q.push_back(e);
        fetch_en = 1'b1;
        pc       = fetch_pc;
        thread   = fetch_thread;
        step();
        fetch_en = 1'b0;
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while ((instr_q.size() != 0 || ctrl_q.size() != 0) && waited < 40) begin
            step();
            waited++;
        end
        if (instr_q.size() != 0 || ctrl_q.size() != 0) begin
            flow_errors++;
            $display("Timeout: %0d fetch results never arrived", ctrl_q.size());
            instr_q.delete();
            ctrl_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = flow_errors + check_errors - test_start_errors;
        test_num++;
        $display("test %0d %-24s %s (%0d errors)", test_num, name,
                 (errs == 0) ? "ok" : "failed", errs);
        test_start_errors = flow_errors + check_errors;
    endtask

    // -------------------------------------------------------------------------
    // Test sequence

    initial begin : main
        logic [7:0] written [16];
        for (int i = 0; i < 256; i++) begin
            imem_model[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            ctrl_model[i] = '0;
        end
        repeat (3) @(posedge clock);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < 8; i++) begin
            step();
            flow_checks++;
            if (instr_valid || ctrl_valid) begin
                flow_errors++;
                $display("Valid output raised with no fetch issued");
            end
        end
        end_test("idle after reset");

        for (int i = 0; i < 16; i++) begin
            written[i] = 8'(lfsr_bits(8));
            host_write({fetch_pkg::region_imem, written[i]}, lfsr_bits(32));
        end
        for (int i = 0; i < 16; i++) begin
            fetch_one(written[i], 2'(lfsr_bits(2)));
        end
        drain_results();
        end_test("instruction readback");

        // Every opcode at pc 0..15, distinct control word per table entry
        host_write({fetch_pkg::region_unlock, 8'h00}, 32'hf);
        for (int i = 0; i < 16; i++) begin
            host_write({fetch_pkg::region_imem, 8'(i)}, {4'(i), 28'(lfsr_bits(28))});
        end
        for (int e = 0; e < 64; e++) begin
            host_write({fetch_pkg::region_cmem, 2'b00, 6'(e)},
                       32'({2'(lfsr_bits(2)), 6'(e)}));
        end
        for (int i = 0; i < 16; i++) begin
            for (int t = 0; t < 4; t++) begin
                fetch_one(8'(i), 2'(t));
            end
        end
        drain_results();
        end_test("per-thread control");

        // Threads 1 and 3 locked
        host_write({fetch_pkg::region_unlock, 8'h00}, 32'h5);
        for (int e = 0; e < 64; e++) begin
            host_write({fetch_pkg::region_cmem, 2'b00, 6'(e)},
                       32'({2'(lfsr_bits(2)), ~6'(e)}));
        end
        for (int i = 0; i < 16; i++) begin
            for (int t = 0; t < 4; t++) begin
                fetch_one(8'(i), 2'(t));
            end
        end
        drain_results();
        end_test("locked tables");

        // Gap tracking starts fresh with the first result of the burst
        instr_seen = 1'b0;
        ctrl_seen  = 1'b0;
        burst_mode = 1'b1;
        for (int i = 0; i < 48; i++) begin
            fetch_one(8'(lfsr_bits(8)), 2'(lfsr_bits(2)));
        end
        drain_results();
        burst_mode = 1'b0;
        end_test("back-to-back burst");

        // Ignored writes aimed at the pcs and thread 0 entries fetched below
        for (int i = 0; i < 16; i++) begin
            host_write({fetch_pkg::region_none, written[i]}, lfsr_bits(32));
            host_write({fetch_pkg::region_none, 8'(i)}, lfsr_bits(32));
        end
        for (int i = 0; i < 16; i++) begin
            fetch_one(written[i], 2'(lfsr_bits(2)));
            fetch_one(8'(i), 2'b00);
        end
        drain_results();
        end_test("ignored host region");

        $display("checks %0d, errors %0d", check_count + flow_checks,
                 check_errors + flow_errors);
        if (check_errors + flow_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator.
# Exits non-zero unless the log holds the pass message.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f --top-module fetch_tb \
        -Mdir obj_dir -o fetch_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* src/fetch_pkg.sv */
// -------------------------------------------------------------------------
// Shared definitions for the fetch front end: instruction layout, memory
// sizes and the opcode and host region encodings. Referenced by scope only.
// -------------------------------------------------------------------------

package fetch_pkg;

    // -------------------------------------------------------------------------
    // Instruction format, from the top bit down: opcode, D, A, B

    localparam int instr_width  = 32;
    localparam int opcode_width = 4;
    localparam int d_width      = 10;
    localparam int a_width      = 9;
    localparam int b_width      = 9;
    localparam int d_half_width = 5;

    // Field positions
    localparam int b_lsb      = 0;
    localparam int a_lsb      = b_lsb + b_width;
    localparam int d_lsb      = a_lsb + a_width;
    localparam int opcode_lsb = d_lsb + d_width;

    // -------------------------------------------------------------------------
    // Memory sizes

    localparam int imem_addr_width = 8;
    localparam int imem_depth      = 256;

    localparam int thread_count = 4;
    localparam int thread_width = 2;

    // One sixteen-entry table per thread, packed into a single RAM
    localparam int ctrl_width      = 8;
    localparam int cmem_addr_width = thread_width + opcode_width;
    localparam int cmem_depth      = 64;

    // Host configuration port
    localparam int host_addr_width = 10;
    localparam int host_data_width = 32;

    // -------------------------------------------------------------------------
    // Encodings

    typedef enum logic [opcode_width-1:0] {
        op_nop  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_and  = 4'h3,
        op_or   = 4'h4,
        op_xor  = 4'h5,
        op_shl  = 4'h6,
        op_shr  = 4'h7,
        op_mul  = 4'h8,
        op_ld   = 4'h9,
        op_st   = 4'ha,
        op_jmp  = 4'hb,
        op_jz   = 4'hc,
        op_jnz  = 4'hd,
        op_call = 4'he,
        op_ret  = 4'hf
    } opcode_e;

    // Top two bits of the host address
    typedef enum logic [1:0] {
        region_imem   = 2'b00,
        region_cmem   = 2'b01,
        region_unlock = 2'b10,
        region_none   = 2'b11
    } host_region_e;

endpackage

/* src/fetch_top.sv */
// -------------------------------------------------------------------------
// Fetch front end top level. Host writes go through the loader, fetches
// go straight into the pipeline.
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module fetch_top (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic                                  host_wren,
    input  logic [fetch_pkg::host_addr_width-1:0] host_addr,
    input  logic [fetch_pkg::host_data_width-1:0] host_data,
    input  logic                                  fetch_en,
    input  logic [fetch_pkg::imem_addr_width-1:0] pc,
    input  logic [fetch_pkg::thread_width-1:0]    thread,
    output logic [fetch_pkg::instr_width-1:0]     instr,
    output fetch_pkg::opcode_e                    opcode,
    output logic [fetch_pkg::d_width-1:0]         d_operand,
    output logic [fetch_pkg::d_half_width-1:0]    d_lower,
    output logic [fetch_pkg::d_half_width-1:0]    d_upper,
    output logic [fetch_pkg::a_width-1:0]         a_operand,
    output logic [fetch_pkg::b_width-1:0]         b_operand,
    output logic                                  instr_valid,
    output logic [fetch_pkg::ctrl_width-1:0]      ctrl,
    output logic                                  ctrl_valid
);

    logic                                  imem_wren;
    logic [fetch_pkg::imem_addr_width-1:0] imem_write_addr;
    logic [fetch_pkg::instr_width-1:0]     imem_write_data;
    logic                                  cmem_wren;
    logic [fetch_pkg::cmem_addr_width-1:0] cmem_write_addr;
    logic [fetch_pkg::ctrl_width-1:0]      cmem_write_data;

    program_loader loader_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .host_wren       (host_wren),
        .host_addr       (host_addr),
        .host_data       (host_data),
        .imem_wren       (imem_wren),
        .imem_write_addr (imem_write_addr),
        .imem_write_data (imem_write_data),
        .cmem_wren       (cmem_wren),
        .cmem_write_addr (cmem_write_addr),
        .cmem_write_data (cmem_write_data)
    );

    instruction_memory fetch_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .imem_wren       (imem_wren),
        .imem_write_addr (imem_write_addr),
        .imem_write_data (imem_write_data),
        .cmem_wren       (cmem_wren),
        .cmem_write_addr (cmem_write_addr),
        .cmem_write_data (cmem_write_data),
        .fetch_en        (fetch_en),
        .pc              (pc),
        .thread          (thread),
        .instr           (instr),
        .opcode          (opcode),
        .d_operand       (d_operand),
        .d_lower         (d_lower),
        .d_upper         (d_upper),
        .a_operand       (a_operand),
        .b_operand       (b_operand),
        .instr_valid     (instr_valid),
        .ctrl            (ctrl),
        .ctrl_valid      (ctrl_valid)
    );

endmodule

/* src/field_extractor.sv */
// -------------------------------------------------------------------------
// Splits an instruction word into its opcode and operand fields.
// Purely combinational.
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module field_extractor (
    input  logic [fetch_pkg::instr_width-1:0]  instruction,
    output fetch_pkg::opcode_e                 opcode,
    output logic [fetch_pkg::d_width-1:0]      d_operand,
    output logic [fetch_pkg::d_half_width-1:0] d_lower,
    output logic [fetch_pkg::d_half_width-1:0] d_upper,
    output logic [fetch_pkg::a_width-1:0]      a_operand,
    output logic [fetch_pkg::b_width-1:0]      b_operand
);

    assign opcode = fetch_pkg::opcode_e'(
        instruction[fetch_pkg::opcode_lsb +: fetch_pkg::opcode_width]);

    assign d_operand = instruction[fetch_pkg::d_lsb +: fetch_pkg::d_width];
    assign a_operand = instruction[fetch_pkg::a_lsb +: fetch_pkg::a_width];
    assign b_operand = instruction[fetch_pkg::b_lsb +: fetch_pkg::b_width];

    // Split destination halves of D
    assign d_lower = d_operand[0 +: fetch_pkg::d_half_width];
    assign d_upper = d_operand[fetch_pkg::d_half_width +: fetch_pkg::d_half_width];

endmodule

/* src/instruction_memory.sv */
// -------------------------------------------------------------------------
// Four-stage fetch pipeline: instruction read, instruction register and
// field split, opcode table read, control register. No back-pressure.
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module instruction_memory (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic                                  imem_wren,
    input  logic [fetch_pkg::imem_addr_width-1:0] imem_write_addr,
    input  logic [fetch_pkg::instr_width-1:0]     imem_write_data,
    input  logic                                  cmem_wren,
    input  logic [fetch_pkg::cmem_addr_width-1:0] cmem_write_addr,
    input  logic [fetch_pkg::ctrl_width-1:0]      cmem_write_data,
    input  logic                                  fetch_en,
    input  logic [fetch_pkg::imem_addr_width-1:0] pc,
    input  logic [fetch_pkg::thread_width-1:0]    thread,
    output logic [fetch_pkg::instr_width-1:0]     instr,
    output fetch_pkg::opcode_e                    opcode,
    output logic [fetch_pkg::d_width-1:0]         d_operand,
    output logic [fetch_pkg::d_half_width-1:0]    d_lower,
    output logic [fetch_pkg::d_half_width-1:0]    d_upper,
    output logic [fetch_pkg::a_width-1:0]         a_operand,
    output logic [fetch_pkg::b_width-1:0]         b_operand,
    output logic                                  instr_valid,
    output logic [fetch_pkg::ctrl_width-1:0]      ctrl,
    output logic                                  ctrl_valid
);

    logic [fetch_pkg::instr_width-1:0]  imem_read_data;
    logic [fetch_pkg::ctrl_width-1:0]   cmem_read_data;
    logic                               imem_read_valid;
    logic                               cmem_read_valid;
    logic [fetch_pkg::thread_width-1:0] thread_s0;
    logic [fetch_pkg::thread_width-1:0] thread_s1;

    // -------------------------------------------------------------------------
    // Stage 0, instruction read

    sdp_ram #(
        .word_width (fetch_pkg::instr_width),
        .addr_width (fetch_pkg::imem_addr_width),
        .depth      (fetch_pkg::imem_depth)
    ) imem_ram_i (
        .clock      (clock),
        .wren       (imem_wren),
        .write_addr (imem_write_addr),
        .write_data (imem_write_data),
        .rden       (fetch_en),
        .read_addr  (pc),
        .read_data  (imem_read_data)
    );

    // -------------------------------------------------------------------------
    // Stage 1, instruction register and field split

    always @(posedge clock) begin
        thread_s0 <= thread;
        thread_s1 <= thread_s0;
        instr     <= imem_read_data;
    end

    field_extractor fields_i (
        .instruction (instr),
        .opcode      (opcode),
        .d_operand   (d_operand),
        .d_lower     (d_lower),
        .d_upper     (d_upper),
        .a_operand   (a_operand),
        .b_operand   (b_operand)
    );

    // -------------------------------------------------------------------------
    // Stage 2, control read for the issuing thread

    opcode_control_mem cmem_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .wren        (cmem_wren),
        .write_addr  (cmem_write_addr),
        .write_data  (cmem_write_data),
        .rden        (instr_valid),
        .read_thread (thread_s1),
        .read_opcode (opcode),
        .read_data   (cmem_read_data)
    );

    // -------------------------------------------------------------------------
    // Stage 3, control register

    always @(posedge clock) begin
        ctrl <= cmem_read_data;
    end

    // Valid bits ride alongside the data
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            imem_read_valid <= 1'b0;
            instr_valid     <= 1'b0;
            cmem_read_valid <= 1'b0;
            ctrl_valid      <= 1'b0;
        end else begin
            imem_read_valid <= fetch_en;
            instr_valid     <= imem_read_valid;
            cmem_read_valid <= instr_valid;
            ctrl_valid      <= cmem_read_valid;
        end
    end

    // Control word lands exactly two cycles behind its instruction
    ctrl_follows_instr_a : assert property (
        @(posedge clock) disable iff (!rst_n)
        ctrl_valid == $past(instr_valid, 2)
    ) else $error("ctrl_valid out of step with instr_valid");

endmodule

/* src/opcode_control_mem.sv */
// -------------------------------------------------------------------------
// Per-thread opcode to control word tables. All threads share one RAM,
// indexed by {thread, opcode}; the host writes with the same layout.
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module opcode_control_mem (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 wren,
    input  logic [fetch_pkg::cmem_addr_width-1:0] write_addr,
    input  logic [fetch_pkg::ctrl_width-1:0]      write_data,
    input  logic                                 rden,
    input  logic [fetch_pkg::thread_width-1:0]    read_thread,
    input  logic [fetch_pkg::opcode_width-1:0]    read_opcode,
    output logic [fetch_pkg::ctrl_width-1:0]      read_data
);

    logic [fetch_pkg::cmem_addr_width-1:0] read_addr;

    // Thread selects the table, opcode the entry inside it
    assign read_addr = {read_thread, read_opcode};

    // -------------------------------------------------------------------------
    // Table storage

    sdp_ram #(
        .word_width (fetch_pkg::ctrl_width),
        .addr_width (fetch_pkg::cmem_addr_width),
        .depth      (fetch_pkg::cmem_depth)
    ) table_ram_i (
        .clock      (clock),
        .wren       (wren),
        .write_addr (write_addr),
        .write_data (write_data),
        .rden       (rden),
        .read_addr  (read_addr),
        .read_data  (read_data)
    );

    // -------------------------------------------------------------------------
    // Checks

    // Thread number carried down the pipeline must name a real table
    thread_in_range_a : assert property (
        @(posedge clock) disable iff (!rst_n)
        rden |-> (int'(read_thread) < fetch_pkg::thread_count)
    ) else $error("control table read for thread %0d", read_thread);

endmodule

/* src/program_loader.sv */
// -------------------------------------------------------------------------
// Host configuration block. Decodes host writes into instruction memory,
// opcode table and unlock register writes; locked tables ignore writes.
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module program_loader (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic                                  host_wren,
    input  logic [fetch_pkg::host_addr_width-1:0] host_addr,
    input  logic [fetch_pkg::host_data_width-1:0] host_data,
    output logic                                  imem_wren,
    output logic [fetch_pkg::imem_addr_width-1:0] imem_write_addr,
    output logic [fetch_pkg::instr_width-1:0]     imem_write_data,
    output logic                                  cmem_wren,
    output logic [fetch_pkg::cmem_addr_width-1:0] cmem_write_addr,
    output logic [fetch_pkg::ctrl_width-1:0]      cmem_write_data
);

    fetch_pkg::host_region_e             region;
    logic [fetch_pkg::thread_width-1:0]  target_thread;
    logic [fetch_pkg::thread_count-1:0]  unlock_q;
    logic                                unlock_wren;

    // -------------------------------------------------------------------------
    // Address decode

    assign region = fetch_pkg::host_region_e'(
        host_addr[fetch_pkg::host_addr_width-1 -: 2]);

    // Thread sits just above the opcode in the table address
    assign target_thread = host_addr[fetch_pkg::cmem_addr_width-1 -: fetch_pkg::thread_width];

    assign unlock_wren = host_wren && (region == fetch_pkg::region_unlock);

    assign imem_wren       = host_wren && (region == fetch_pkg::region_imem);
    assign imem_write_addr = host_addr[fetch_pkg::imem_addr_width-1:0];
    assign imem_write_data = host_data[fetch_pkg::instr_width-1:0];

    assign cmem_wren       = host_wren && (region == fetch_pkg::region_cmem)
                             && unlock_q[target_thread];
    assign cmem_write_addr = host_addr[fetch_pkg::cmem_addr_width-1:0];
    assign cmem_write_data = host_data[fetch_pkg::ctrl_width-1:0];

    // -------------------------------------------------------------------------
    // Unlock register, one bit per thread, all locked out of reset

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            unlock_q <= '0;
        end else if (unlock_wren) begin
            unlock_q <= host_data[fetch_pkg::thread_count-1:0];
        end
    end

    // One host write targets one memory at most
    one_target_a : assert property (
        @(posedge clock) disable iff (!rst_n)
        !(imem_wren && cmem_wren)
    ) else $error("host write hit both memories");

endmodule

/* src/sdp_ram.sv */
// -------------------------------------------------------------------------
// Simple dual-port RAM, one write port and one registered read port.
// Used for both the instruction store and the opcode control tables.
// -------------------------------------------------------------------------

`timescale 1ns/1ps

module sdp_ram #(
    parameter int word_width = 32,
    parameter int addr_width = 8,
    parameter int depth      = 256
) (
    input  logic                  clock,
    input  logic                  wren,
    input  logic [addr_width-1:0] write_addr,
    input  logic [word_width-1:0] write_data,
    input  logic                  rden,
    input  logic [addr_width-1:0] read_addr,
    output logic [word_width-1:0] read_data
);

    logic [word_width-1:0] mem [depth];

    // Contents start cleared, the host loads everything
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // -------------------------------------------------------------------------
    // Write port

    always @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
    end

    // -------------------------------------------------------------------------
    // Read port
    // Holds its value while rden is low; a same-address write returns old data

    always @(posedge clock) begin
        if (rden) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

/* vlog.f */
src/fetch_pkg.sv
src/sdp_ram.sv
src/field_extractor.sv
src/opcode_control_mem.sv
src/instruction_memory.sv
src/program_loader.sv
src/fetch_top.sv
dv/fetch_tb.sv
